// File: source/rx_lbuf_pkg.sv
`default_nettype none

package rx_lbuf_pkg;

    ////////////////////
    // host buffer addressing

    localparam int unsigned addr_w = 64;        // full host address
    localparam int unsigned hi_lo_split = 32;   // upper bits from here mark a 64-bit buffer

    typedef logic [addr_w-1:0] lbuf_addr_t;

    ////////////////////
    // slot ids
    typedef logic slot_t;

    localparam slot_t slot1_id = 1'b0;
    localparam slot_t slot2_id = 1'b1;

endpackage

`default_nettype wire

// File: source/rx_pkt_pkg.sv
`default_nettype none

package rx_pkt_pkg;

    ////////////////////
    // packet stream words

    localparam int unsigned data_w = 64;    // one word per accept
    localparam int unsigned word_bytes = 8; // host address step per word

    typedef logic [data_w-1:0] pkt_word_t;

endpackage

`default_nettype wire

// File: source/rx_host_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module rx_host_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // host posting
    input  wire logic                   host_wr,
    input  wire rx_lbuf_pkg::slot_t     host_slot,
    input  wire rx_lbuf_pkg::lbuf_addr_t host_addr,
    // slots toward the giver
    output rx_lbuf_pkg::lbuf_addr_t     slot1_addr,
    output logic                        slot1_en,
    input  wire logic                   slot1_dn,
    output rx_lbuf_pkg::lbuf_addr_t     slot2_addr,
    output logic                        slot2_en,
    input  wire logic                   slot2_dn,
    // host status
    output logic [1:0]                  slot_busy,
    output logic                        host_done,
    output rx_lbuf_pkg::slot_t          host_done_slot
);
    import rx_lbuf_pkg::*;

    logic [1:0] busy;   // bit 0 slot 1, bit 1 slot 2

    ////////////////////
    // busy flags and done report
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 2'b00;
            host_done <= 1'b0;
        end else begin
            host_done <= slot1_dn | slot2_dn;   // one cycle after the slot returns
            // take a post only into a free slot
            if (host_wr && host_slot == slot1_id && !busy[0]) busy[0] <= 1'b1;
            if (host_wr && host_slot == slot2_id && !busy[1]) busy[1] <= 1'b1;
            if (slot1_dn) busy[0] <= 1'b0;      // returned, free again
            if (slot2_dn) busy[1] <= 1'b0;
        end
    end

    // address regs, payload only
    always_ff @(posedge clk) begin
        if (host_wr && host_slot == slot1_id && !busy[0]) slot1_addr <= host_addr;
        if (host_wr && host_slot == slot2_id && !busy[1]) slot2_addr <= host_addr;
        // name the slot that came back, slot 2 only when it was its pulse
        host_done_slot <= slot2_dn ? slot2_id : slot1_id;
    end

    assign slot1_en  = busy[0];   // high until returned
    assign slot2_en  = busy[1];
    assign slot_busy = busy;

endmodule

`default_nettype wire

// File: source/rx_gv_lbuf.sv
`timescale 1ns/1ns
`default_nettype none

module rx_gv_lbuf (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // slot 1
    input  wire rx_lbuf_pkg::lbuf_addr_t slot1_addr,
    input  wire logic                    slot1_en,
    output logic                         slot1_dn,
    // slot 2
    input  wire rx_lbuf_pkg::lbuf_addr_t slot2_addr,
    input  wire logic                    slot2_en,
    output logic                         slot2_dn,
    // current buffer toward the filler
    output rx_lbuf_pkg::lbuf_addr_t      lbuf_addr,
    output logic                         lbuf_en,
    output logic                         lbuf64b,
    input  wire logic                    lbuf_dn
);
    import rx_lbuf_pkg::*;

    // one-hot, so a stray value falls into default
    typedef enum logic [3:0] {
        wait1 = 4'b0001,
        give1 = 4'b0010,
        wait2 = 4'b0100,
        give2 = 4'b1000
    } gv_state_t;

    gv_state_t state;

    ////////////////////
    // strict alternation, slot 1 first
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= wait1;
            lbuf_en  <= 1'b0;
            slot1_dn <= 1'b0;
            slot2_dn <= 1'b0;
        end else begin
            slot1_dn <= 1'b0;   // pulses
            slot2_dn <= 1'b0;
            case (state)
                wait1: begin
                    if (slot1_en) begin   // slot 2 may be ready, still waits
                        lbuf_en <= 1'b1;
                        state   <= give1;
                    end
                end
                give1: begin
                    if (lbuf_dn) begin
                        lbuf_en  <= 1'b0;
                        slot1_dn <= 1'b1; // hand back to host side
                        state    <= wait2;
                    end
                end
                wait2: begin
                    if (slot2_en) begin
                        lbuf_en <= 1'b1;
                        state   <= give2;
                    end
                end
                give2: begin
                    if (lbuf_dn) begin
                        lbuf_en  <= 1'b0;
                        slot2_dn <= 1'b1;
                        state    <= wait1;
                    end
                end
                default: begin
                    lbuf_en <= 1'b0;
                    state   <= wait1; // recover
                end
            endcase
        end
    end

    // latch address and 64-bit flag on give
    always_ff @(posedge clk) begin
        if (state == wait1 && slot1_en) begin
            lbuf_addr <= slot1_addr;
            lbuf64b   <= |slot1_addr[addr_w-1:hi_lo_split];
        end else if (state == wait2 && slot2_en) begin
            lbuf_addr <= slot2_addr;
            lbuf64b   <= |slot2_addr[addr_w-1:hi_lo_split];
        end
    end

endmodule

`default_nettype wire

// File: source/rx_fill_cnt.sv
`timescale 1ns/1ns
`default_nettype none

module rx_fill_cnt #(
    parameter int lbuf_words = 8,
    localparam int cnt_w = $clog2(lbuf_words + 1)   // must hold lbuf_words itself
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             lbuf_en,
    input  wire logic             word_acc,
    output logic [cnt_w-1:0]      offset,
    output logic                  full
);

    ////////////////////
    // word offset in the current buffer
    always_ff @(posedge clk) begin
        if (rst || !lbuf_en) begin   // no buffer given, next one starts at zero
            offset <= '0;
            full   <= 1'b0;
        end else if (word_acc) begin
            offset <= offset + 1'b1;
            if (offset == cnt_w'(lbuf_words - 1))
                full <= 1'b1;       // last word counted
        end
    end

endmodule

`default_nettype wire

// File: source/rx_lbuf_fill.sv
`timescale 1ns/1ns
`default_nettype none

module rx_lbuf_fill #(
    parameter int off_w = 4     // offset width, from the counter
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // current buffer
    input  wire rx_lbuf_pkg::lbuf_addr_t lbuf_addr,
    input  wire logic                    lbuf_en,
    input  wire logic                    lbuf64b,
    output logic                         lbuf_dn,
    // packet source
    input  wire logic                    pkt_valid,
    input  wire rx_pkt_pkg::pkt_word_t   pkt_data,
    output logic                         pkt_ready,
    // counter
    output logic                         word_acc,
    input  wire logic [off_w-1:0]        offset,
    input  wire logic                    full,
    // memory write
    output logic                         mem_wr,
    output rx_lbuf_pkg::lbuf_addr_t      mem_wr_addr,
    output rx_pkt_pkg::pkt_word_t        mem_wr_data,
    output logic                         mem_wr_64b
);
    import rx_lbuf_pkg::*;
    import rx_pkt_pkg::*;

    ////////////////////
    // handshake
    assign pkt_ready = lbuf_en & ~full;         // buffer given and room left
    assign word_acc  = pkt_valid & pkt_ready;

    // full rises with the last write, lbuf_en drops one cycle later
    assign lbuf_dn = lbuf_en & full;

    ////////////////////
    // write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr <= 1'b0;
        end else begin
            mem_wr <= word_acc;     // one cycle after accept
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (word_acc) begin
            mem_wr_addr <= lbuf_addr + lbuf_addr_t'(offset) * lbuf_addr_t'(word_bytes);
            mem_wr_data <= pkt_data;
            mem_wr_64b  <= lbuf64b;   // selects host write format
        end
    end

endmodule

`default_nettype wire

// File: source/rx_lbuf_top.sv
`timescale 1ns/1ns
`default_nettype none

module rx_lbuf_top #(
    parameter int lbuf_words = 8
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // host
    input  wire logic                    host_wr,
    input  wire rx_lbuf_pkg::slot_t      host_slot,
    input  wire rx_lbuf_pkg::lbuf_addr_t host_addr,
    output logic [1:0]                   slot_busy,
    output logic                         host_done,
    output rx_lbuf_pkg::slot_t           host_done_slot,
    // packets
    input  wire logic                    pkt_valid,
    input  wire rx_pkt_pkg::pkt_word_t   pkt_data,
    output logic                         pkt_ready,
    // memory writes
    output logic                         mem_wr,
    output rx_lbuf_pkg::lbuf_addr_t      mem_wr_addr,
    output rx_pkt_pkg::pkt_word_t        mem_wr_data,
    output logic                         mem_wr_64b
);
    import rx_lbuf_pkg::*;

    localparam int off_w = $clog2(lbuf_words + 1);  // same as counter width

    ////////////////////
    // internal wires
    lbuf_addr_t       slot1_addr, slot2_addr, lbuf_addr;
    logic             slot1_en, slot2_en, slot1_dn, slot2_dn;
    logic             lbuf_en, lbuf64b, lbuf_dn;
    logic             word_acc, full;
    logic [off_w-1:0] offset;

    rx_host_ctrl host_ctrl_i (
        .clk, .rst,
        .host_wr, .host_slot, .host_addr,
        .slot1_addr, .slot1_en, .slot1_dn,
        .slot2_addr, .slot2_en, .slot2_dn,
        .slot_busy, .host_done, .host_done_slot
    );

    rx_gv_lbuf gv_lbuf_i (
        .clk, .rst,
        .slot1_addr, .slot1_en, .slot1_dn,
        .slot2_addr, .slot2_en, .slot2_dn,
        .lbuf_addr, .lbuf_en, .lbuf64b, .lbuf_dn
    );

    rx_fill_cnt #(.lbuf_words(lbuf_words)) fill_cnt_i (
        .clk, .rst, .lbuf_en, .word_acc, .offset, .full
    );

    rx_lbuf_fill #(.off_w(off_w)) lbuf_fill_i (
        .clk, .rst,
        .lbuf_addr, .lbuf_en, .lbuf64b, .lbuf_dn,
        .pkt_valid, .pkt_data, .pkt_ready,
        .word_acc, .offset, .full,
        .mem_wr, .mem_wr_addr, .mem_wr_data, .mem_wr_64b
    );

endmodule

`default_nettype wire

// File: bench/rx_lbuf_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rx_lbuf_chk #(
    parameter int lbuf_words = 8
) (
    input wire logic                    clk, rst, host_wr, host_done,
    input wire logic                    pkt_valid, pkt_ready, mem_wr, mem_wr_64b,
    input wire logic [1:0]              slot_busy,
    input wire rx_lbuf_pkg::slot_t      host_slot, host_done_slot,
    input wire rx_lbuf_pkg::lbuf_addr_t host_addr, mem_wr_addr,
    input wire rx_pkt_pkg::pkt_word_t   pkt_data, mem_wr_data
);
    import rx_lbuf_pkg::*;
    import rx_pkt_pkg::*;

    lbuf_addr_t post_addr [2];      // last post each slot took
    logic [1:0] post_busy;
    logic [1:0] slot_free;
    slot_t      exp_slot;           // slot owed the next buffer
    lbuf_addr_t cur_addr;
    int         wr_cnt;             // writes seen in this buffer
    logic       acc_d;              // accept one cycle ago
    pkt_word_t  acc_data;
    logic       fail_flag = 1'b0;

    // a done pulse frees its slot in the same cycle
    assign slot_free = ~post_busy | ({host_done_slot, ~host_done_slot} & {2{host_done}});
    assign cur_addr  = post_addr[exp_slot];

    ////////////////////
    // reference tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            post_busy <= 2'b00;
            exp_slot  <= slot1_id;  // slot 1 always first
            wr_cnt    <= 0;
            acc_d     <= 1'b0;
        end else begin
            acc_d <= pkt_valid && pkt_ready;
            if (pkt_valid && pkt_ready)
                acc_data <= pkt_data;
            if (host_done) begin
                post_busy[host_done_slot] <= 1'b0;
                exp_slot <= ~exp_slot;  // strict turn taking
                wr_cnt   <= 0;
            end else if (mem_wr) begin
                wr_cnt <= wr_cnt + 1;
            end
            if (host_wr && slot_free[host_slot]) begin   // busy slot drops the post
                post_addr[host_slot] <= host_addr;
                post_busy[host_slot] <= 1'b1;
            end
        end
    end

    ////////////////////
    // properties
    a_reset_clear: assert property (@(posedge clk) $fell(rst) |->
        !mem_wr && !host_done && !pkt_ready && slot_busy == 2'b00)
        else begin
            fail_flag = 1'b1;
            $error("outputs not low after reset");
        end

    a_wr_after_acc: assert property (@(posedge clk) disable iff (rst) mem_wr == acc_d)
        else begin
            fail_flag = 1'b1;
            $error("mem_wr not one cycle after accept");
        end

    // 64-bit format whenever any address bit above 31 is set
    a_wr_content: assert property (@(posedge clk) disable iff (rst) mem_wr |->
        wr_cnt < lbuf_words && mem_wr_data == acc_data
        && mem_wr_addr == cur_addr + lbuf_addr_t'(wr_cnt) * lbuf_addr_t'(word_bytes)
        && mem_wr_64b == (cur_addr[63:32] != 32'h0))
        else begin
            fail_flag = 1'b1;
            $error("wrong write address, data or 64b flag");
        end

    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        mem_wr && wr_cnt == lbuf_words - 1 |-> ##2 host_done && host_done_slot == exp_slot)
        else begin
            fail_flag = 1'b1;
            $error("host_done late or wrong slot");
        end

    a_done_state: assert property (@(posedge clk) disable iff (rst) host_done |->
        wr_cnt == lbuf_words && !slot_busy[host_done_slot])
        else begin
            fail_flag = 1'b1;
            $error("host_done without full buffer or busy left");
        end

    // idle with no slot, or buffer full and not yet returned
    a_idle: assert property (@(posedge clk) disable iff (rst)
        post_busy == 2'b00 || (wr_cnt == lbuf_words && !host_done) |-> !pkt_ready && !mem_wr)
        else begin
            fail_flag = 1'b1;
            $error("ready or write while no buffer open");
        end

endmodule

`default_nettype wire

// File: bench/rx_lbuf_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rx_lbuf_tb;
    import rx_lbuf_pkg::*;
    import rx_pkt_pkg::*;

    localparam int buf_words = 8;
    localparam int n_bufs    = 6;
    // 48 words with gaps up to 4x, plus posting slack per buffer
    localparam int cycle_limit = 2000;

    logic       clk, rst, host_wr, host_done, pkt_valid, pkt_ready, mem_wr, mem_wr_64b;
    logic [1:0] slot_busy;
    slot_t      host_slot, host_done_slot;
    lbuf_addr_t host_addr, mem_wr_addr;
    pkt_word_t  pkt_data, mem_wr_data;

    logic [31:0] rng_addr = 32'd37789;
    logic [31:0] rng_gap  = ~32'd37789;     // second stream off the same seed
    pkt_word_t   word_seq = 64'd1;          // data counts up from here
    int          post_cnt = 0;
    int          done_cnt = 0;
    int          cycles   = 0;

    rx_lbuf_top #(.lbuf_words(buf_words)) dut_i (.*);

    bind rx_lbuf_top rx_lbuf_chk #(.lbuf_words(lbuf_words)) chk_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    // post one buffer, then a stray write the busy slot has to drop
    task automatic post_buffer(input slot_t s);
        lbuf_addr_t  a;
        logic [31:0] lo;
        rng_addr = xorshift(rng_addr);
        lo = rng_addr;
        rng_addr = xorshift(rng_addr);
        a = {post_cnt[0] ? (rng_addr | 32'h1) : 32'h0, lo[31:3], 3'b000};  // every other one above 4G
        post_cnt++;
        host_wr   <= 1'b1;
        host_slot <= s;
        host_addr <= a;
        @(posedge clk);
        host_addr <= ~a;    // same slot, now busy
        @(posedge clk);
        host_wr <= 1'b0;
    endtask

    ////////////////////
    // reset, posting and end of run
    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        host_wr   = 1'b0;
        host_slot = slot1_id;
        host_addr = '0;
        pkt_valid = 1'b0;
        pkt_data  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        post_buffer(slot2_id);      // slot 2 first, slot 1 still gets the first buffer
        post_buffer(slot1_id);
        while (done_cnt < n_bufs) begin
            @(posedge clk);
            if (host_done) begin
                done_cnt++;
                if (done_cnt <= n_bufs - 2)
                    post_buffer(host_done_slot);    // repost the returned slot
            end
        end
        repeat (3) @(posedge clk);  // last properties still pending
        if (dut_i.chk_i.fail_flag) begin
            stop_on_failure($sformatf("[ERROR] %0t: checker assertion failed", $time));
        end else begin
            $display("test passed");
            $finish;
        end
    end

    ////////////////////
    // packet source, holds a word until taken
    always @(posedge clk) begin
        if (rst) begin
            pkt_valid <= 1'b0;
        end else if (!pkt_valid || pkt_ready) begin
            if (pkt_valid)
                word_seq = word_seq + 64'd1;   // previous word went in
            rng_gap = xorshift(rng_gap);
            pkt_valid <= rng_gap[7];           // idle about half the time
            pkt_data  <= word_seq;
        end
    end

    // first failing property ends the run
    always @(posedge clk) begin
        if (dut_i.chk_i.fail_flag)
            stop_on_failure($sformatf("[ERROR] %0t: checker assertion failed", $time));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
            stop_on_failure($sformatf("timeout: only %0d of %0d buffers completed",
                                      done_cnt, n_bufs));
    end

endmodule

`default_nettype wire

// File: src.f
source/rx_lbuf_pkg.sv
source/rx_pkt_pkg.sv
source/rx_host_ctrl.sv
source/rx_gv_lbuf.sv
source/rx_fill_cnt.sv
source/rx_lbuf_fill.sv
source/rx_lbuf_top.sv
bench/rx_lbuf_chk.sv
bench/rx_lbuf_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rx_lbuf_tb \
    -f src.f -o rx_lbuf_sim || { echo "build failed"; exit 1; }
./obj_dir/rx_lbuf_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"
